// File: verilog/dmem_params.svh
// data memory sizing
// word width, depth and word index width for rtl and testbench
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

`define DMEM_XLEN   32              // data word width in bits
`define DMEM_WORDS  256             // depth in words
`define DMEM_IDX_W  8               // must cover DMEM_WORDS

// byte lanes per word
`define DMEM_BYTES  (`DMEM_XLEN / 8)

`endif

// File: verilog/dmem_pkg.sv
// data memory shared types
// word, lane enable, word index and the rv32 style access width code
// plus the legality rule for a width code in a given direction
`include "dmem_params.svh"

package dmem_pkg;

    typedef logic [`DMEM_XLEN-1:0]  word_t;      // one data word
    typedef logic [`DMEM_BYTES-1:0] byte_en_t;   // one bit per byte lane
    typedef logic [`DMEM_IDX_W-1:0] word_idx_t;  // word address into the array

    // width code in funct3 encoding
    // codes 3, 6 and 7 are not assigned and always illegal
    typedef enum logic [2:0] {
        acc_byte   = 3'd0,  // lb / sb
        acc_half   = 3'd1,  // lh / sh
        acc_word   = 3'd2,  // lw / sw
        acc_byte_u = 3'd4,  // lbu only
        acc_half_u = 3'd5   // lhu only
    } access_e;

    // legal width code for the direction
    // unsigned forms exist for loads only
    function automatic logic acc_legal(access_e code, logic is_write);
        logic ok;
        case (code)
            acc_byte, acc_half, acc_word: begin
                ok = 1'b1;
            end
            acc_byte_u, acc_half_u: begin
                ok = !is_write;             // no unsigned store
            end
            default: begin
                ok = 1'b0;                  // unassigned encodings
            end
        endcase
        return ok;
    endfunction

endpackage

// File: verilog/dmem_if.sv
// memory access interface
// one word access from the apb controller to the data array
// lane aligned write data and enables go down, registered read data comes back
`timescale 1ns/1ps

interface dmem_if
    import dmem_pkg::*;
();

    word_idx_t idx;     // word index
    word_t     wdata;   // write data already steered into lanes
    byte_en_t  be;      // per lane write enable
    logic      we;      // write strobe
    logic      re;      // read strobe
    word_t     rdata;   // registered read word

    // controller side
    modport ctrl (
        output idx, wdata, be, we, re,
        input  rdata
    );

    // array side
    modport mem (
        input  idx, wdata, be, we, re,
        output rdata
    );

endinterface

// File: verilog/data_mem.sv
// data memory array
// word organised ram built from byte lanes
// lane writes follow be and the read word is registered on re
`timescale 1ns/1ps
`include "dmem_params.svh"

module data_mem (
    input logic clk,
    dmem_if.mem mem
);

    localparam int LANE_W = 8;  // one byte per lane

    // storage as packed lanes per word
    // contents are not cleared on reset
    logic [`DMEM_BYTES-1:0][LANE_W-1:0] ram [`DMEM_WORDS];

    // write port
    // the controller has already shifted the data into its lanes,
    // so lane n of wdata lands in lane n of the word
    always_ff @(posedge clk) begin
        if (mem.we) begin
            for (int lane = 0; lane < `DMEM_BYTES; lane++) begin
                if (mem.be[lane]) begin
                    ram[mem.idx][lane] <= mem.wdata[lane*LANE_W +: LANE_W];
                end
            end
        end
    end

    // read port
    // whole word, one edge after re, held until the next re
    always_ff @(posedge clk) begin
        if (mem.re) begin
            mem.rdata <= ram[mem.idx];      // lane select done by controller
        end
    end

endmodule

// File: verilog/lsu_apb_slave.sv
// apb slave controller for the data memory
// checks alignment, range and width code, steers store data into byte lanes
// and extends the addressed byte or halfword of a load
`timescale 1ns/1ps
`include "dmem_params.svh"

module lsu_apb_slave
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // apb slave side
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  word_t       pwdata,
    input  access_e     acc,        // width code, stable like paddr
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr,
    // array side
    dmem_if.ctrl        mem
);

    localparam int          OFF_W     = $clog2(`DMEM_BYTES);    // byte offset bits
    localparam logic [31:0] MEM_LIMIT = 32'(`DMEM_WORDS * `DMEM_BYTES);

    // idle also covers setup cycles
    // read wait is the second access cycle of a load
    typedef enum logic {
        st_idle,
        st_rd_wait
    } state_e;

    state_e           state_q;
    state_e           state_d;

    logic             first_acc;    // first cycle with penable high
    logic             rd_done;      // load completes this cycle
    logic [OFF_W-1:0] off;          // byte offset inside the word
    logic             misalign;
    logic             out_of_range;
    logic             acc_err;

    logic [OFF_W-1:0] off_q;        // load offset kept for the wait cycle
    access_e          acc_q;        // load width kept for the wait cycle
    word_t            rd_shift;     // addressed lanes moved down to bit 0
    word_t            rd_ext;       // sign or zero extended load result

    assign first_acc = (state_q == st_idle) && psel && penable;
    assign rd_done   = (state_q == st_rd_wait);
    assign off       = paddr[OFF_W-1:0];

    // error rule
    always_comb begin
        case (acc)
            acc_half, acc_half_u: begin
                misalign = off[0];          // halfword on odd byte
            end
            acc_word: begin
                misalign = (off != '0);     // word not on a multiple of 4
            end
            default: begin
                misalign = 1'b0;            // bytes fit anywhere
            end
        endcase
    end

    assign out_of_range = (paddr >= MEM_LIMIT);
    assign acc_err      = misalign || out_of_range || !acc_legal(acc, pwrite);

    // array request
    // index and lane data are driven all the time, only the strobes qualify them
    assign mem.idx   = paddr[OFF_W +: `DMEM_IDX_W];
    assign mem.wdata = pwdata << {off, 3'b000};     // low byte or half into its lane

    always_comb begin
        case (acc)
            acc_byte: begin
                mem.be = byte_en_t'(1) << off;
            end
            acc_half: begin
                mem.be = byte_en_t'(3) << off;  // two lanes from an even offset
            end
            acc_word: begin
                mem.be = '1;
            end
            default: begin
                mem.be = '0;                    // unsigned codes never store
            end
        endcase
    end

    // no strobe on an erring transfer so memory stays untouched
    assign mem.we = first_acc && pwrite && !acc_err;
    assign mem.re = first_acc && !pwrite && !acc_err;

    // transfer tracking
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (mem.re) begin
                    state_d = st_rd_wait;   // one wait state for the array
                end
            end
            st_rd_wait: begin
                state_d = st_idle;          // completes this cycle
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // load context
    // paddr is still stable but the wait cycle only looks at these
    always_ff @(posedge clk) begin
        if (mem.re) begin
            off_q <= off;
            acc_q <= acc;
        end
    end

    // load extraction
    assign rd_shift = mem.rdata >> {off_q, 3'b000};

    always_comb begin
        case (acc_q)
            acc_byte: begin
                rd_ext = {{(`DMEM_XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            end
            acc_byte_u: begin
                rd_ext = {{(`DMEM_XLEN-8){1'b0}}, rd_shift[7:0]};
            end
            acc_half: begin
                rd_ext = {{(`DMEM_XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            end
            acc_half_u: begin
                rd_ext = {{(`DMEM_XLEN-16){1'b0}}, rd_shift[15:0]};
            end
            default: begin
                rd_ext = rd_shift;          // full word, offset is zero
            end
        endcase
    end

    // apb response
    // errors and stores end in the first access cycle, loads one cycle later
    assign pready  = rd_done || (first_acc && (pwrite || acc_err));
    assign pslverr = first_acc && acc_err;
    assign prdata  = rd_done ? rd_ext : '0;     // zero unless a load completes

endmodule

// File: verilog/dmem_subsys.sv
// data memory subsystem top
// apb slave controller in front of the byte lane data array
// joined by the internal memory access interface
`timescale 1ns/1ps

module dmem_subsys
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // apb slave port
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  word_t       pwdata,
    input  access_e     acc,        // load/store width code
    output word_t       prdata,
    output logic        pready,
    output logic        pslverr
);

    // controller to array link
    dmem_if i_mem_if ();

    // protocol, checks and lane steering
    lsu_apb_slave i_lsu (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .acc     (acc),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .mem     (i_mem_if.ctrl)
    );

    // storage
    data_mem i_array (
        .clk (clk),
        .mem (i_mem_if.mem)
    );

endmodule

// File: testbench/dmem_tb.sv
// testbench for the apb data memory subsystem
// byte level shadow model, reference load function and a monitor that
// compares every completed transfer against the expected response
`timescale 1ns/1ps
`include "dmem_params.svh"

module dmem_tb
    import dmem_pkg::*;
();

    localparam int MEM_BYTES     = `DMEM_WORDS * `DMEM_BYTES;
    localparam int BA_W          = $clog2(MEM_BYTES);   // byte address bits
    localparam int READY_TIMEOUT = 20;                  // cycles to wait for pready

    typedef logic [7:0]      shadow_t [MEM_BYTES];
    typedef logic [BA_W-1:0] baddr_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    word_t       pwdata;
    access_e     acc;
    word_t       prdata;
    logic        pready;
    logic        pslverr;

    shadow_t     shadow;        // expected memory contents per byte
    logic [31:0] lcg_state = 32'h91936b0a;

    // expected responses in transfer order
    logic        exp_err_q  [$];
    logic        exp_rd_q   [$];
    word_t       exp_data_q [$];
    string       tag_q      [$];

    int n_checks = 0;
    int n_errors = 0;
    int test_checks0;
    int test_errors0;

    dmem_subsys i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .acc     (acc),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;      // 40 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected pslverr for one transfer
    function automatic logic exp_fault(logic [31:0] addr, access_e code, logic wr);
        logic bad;
        bad = !acc_legal(code, wr);
        if ((code == acc_half || code == acc_half_u) && addr[0]) begin
            bad = 1'b1;                             // odd halfword
        end
        if (code == acc_word && addr[1:0] != 2'b00) begin
            bad = 1'b1;
        end
        if (addr >= 32'(MEM_BYTES)) begin
            bad = 1'b1;                             // past the last word
        end
        return bad;
    endfunction

    // expected load result from the little endian shadow
    function automatic word_t ref_load(shadow_t sh, logic [31:0] addr, access_e code);
        baddr_t a;
        word_t  w;
        a = addr[BA_W-1:0];
        w = {sh[a + baddr_t'(3)], sh[a + baddr_t'(2)], sh[a + baddr_t'(1)], sh[a]};
        case (code)
            acc_byte:   return word_t'(signed'(w[7:0]));
            acc_byte_u: return word_t'(w[7:0]);
            acc_half:   return word_t'(signed'(w[15:0]));
            acc_half_u: return word_t'(w[15:0]);
            default:    return w;                   // whole word
        endcase
    endfunction

    task automatic store_shadow(input logic [31:0] addr, input access_e code, input word_t data);
        baddr_t a;
        a = addr[BA_W-1:0];
        shadow[a] = data[7:0];
        if (code == acc_half || code == acc_word) begin
            shadow[a + baddr_t'(1)] = data[15:8];
        end
        if (code == acc_word) begin
            shadow[a + baddr_t'(2)] = data[23:16];
            shadow[a + baddr_t'(3)] = data[31:24];
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s gave prdata 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error at %0t ns: %s gave flag %b, expected %b", $time, what, got, exp);
        end
    endtask

    // wait states between the first access cycle and pready
    task automatic check_wait(input int got, input int exp, input string what);
        n_checks++;
        if (got != exp) begin
            n_errors++;
            $display("error at %0t ns: %s took %0d wait states, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    // one apb transfer from setup to pready
    task automatic run_transfer(input logic wr, input logic [31:0] addr,
                                input access_e code, input word_t data,
                                input int exp_wait);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        acc     = code;
        pwdata  = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            n_errors++;
            $display("timeout: pready never rose for the transfer at address 0x%08h", addr);
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            check_wait(waited, exp_wait, $sformatf("transfer at 0x%08h", addr));
            @(posedge clk);
            #2;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input access_e code, input word_t data);
        logic err;
        err = exp_fault(addr, code, 1'b1);
        exp_err_q.push_back(err);
        exp_rd_q.push_back(1'b0);
        exp_data_q.push_back('0);
        tag_q.push_back($sformatf("store code %0d at 0x%08h", code, addr));
        if (!err) begin
            store_shadow(addr, code, data);         // only good stores land
        end
        run_transfer(1'b1, addr, code, data, 0);    // stores end in the first access cycle
    endtask

    task automatic apb_read(input logic [31:0] addr, input access_e code);
        logic  err;
        word_t exp;
        err = exp_fault(addr, code, 1'b0);
        if (err) begin
            exp = '0;                               // no data on a failed load
        end else begin
            exp = ref_load(shadow, addr, code);
        end
        exp_err_q.push_back(err);
        exp_rd_q.push_back(1'b1);
        exp_data_q.push_back(exp);
        tag_q.push_back($sformatf("load code %0d at 0x%08h", code, addr));
        run_transfer(1'b0, addr, code, '0, err ? 0 : 1);   // one wait state for the array
    endtask

    // compares each completed transfer with the head of the queues
    always @(negedge clk) begin
        logic  e_err;
        logic  e_rd;
        word_t e_data;
        string tag;
        if (arst_n && psel && penable && pready) begin
            if (exp_err_q.size() == 0) begin
                n_errors++;
                $display("a transfer completed at %0t ns with no transfer outstanding", $time);
            end else begin
                e_err  = exp_err_q.pop_front();
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                tag    = tag_q.pop_front();
                check_err(pslverr, e_err, {tag, " pslverr"});
                if (e_rd) begin
                    check_word(prdata, e_data, tag);
                end
            end
        end
    end

    task automatic start_test();
        test_checks0 = n_checks;
        test_errors0 = n_errors;
    endtask

    task automatic report_test(input string name);
        $display("test %-22s %0d checks, %0d errors", name,
                 n_checks - test_checks0, n_errors - test_errors0);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        acc     = acc_word;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        start_test();
        @(negedge clk);
        check_err(pready, 1'b0, "idle pready");
        check_err(pslverr, 1'b0, "idle pslverr");
        check_word(prdata, '0, "idle");
        report_test("reset");

        // fill every word so later reads never see unwritten lanes
        start_test();
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            apb_write(32'(w * 4), acc_word, lcg_next());
        end
        for (int w = 0; w < `DMEM_WORDS; w++) begin
            apb_read(32'(w * 4), acc_word);
        end
        report_test("word fill");

        start_test();
        for (int w = 16; w < 20; w++) begin
            for (int off = 0; off < 4; off++) begin
                apb_write(32'(w * 4 + off), acc_byte, lcg_next());
                apb_read(32'(w * 4), acc_word);     // other lanes untouched
            end
            for (int off = 0; off < 4; off += 2) begin
                apb_write(32'(w * 4 + off), acc_half, lcg_next());
                apb_read(32'(w * 4), acc_word);
            end
        end
        report_test("byte and half stores");

        start_test();
        for (int w = 32; w < 36; w++) begin
            r = lcg_next();
            apb_write(32'(w * 4), acc_word, (w % 2 == 0) ? (r | 32'h80808080) : r);
        end
        for (int w = 32; w < 36; w++) begin
            for (int off = 0; off < 4; off++) begin
                a = 32'(w * 4 + off);
                apb_read(a, acc_byte);
                apb_read(a, acc_byte_u);
                if (off % 2 == 0) begin
                    apb_read(a, acc_half);
                    apb_read(a, acc_half_u);
                end
                if (off == 0) begin
                    apb_read(a, acc_word);
                end
            end
        end
        report_test("sub-word loads");

        start_test();
        for (int off = 1; off < 4; off++) begin
            a = 32'(160 + off);
            apb_write(a, acc_word, lcg_next());
            apb_read(a, acc_word);
            if (off % 2 == 1) begin
                apb_write(a, acc_half, lcg_next());
                apb_read(a, acc_half);
                apb_read(a, acc_half_u);
            end
        end
        for (int off = 0; off < 4; off++) begin
            apb_write(32'(164 + off), acc_byte_u, lcg_next());  // no unsigned stores
            apb_write(32'(164 + off), acc_half_u, lcg_next());
        end
        for (int c = 3; c < 8; c += 3) begin
            apb_write(32'd160, access_e'(3'(c)), lcg_next());   // unassigned codes 3 and 6
            apb_read(32'd164, access_e'(3'(c + 1)));            // 4 is legal for loads and 7 is not
        end
        apb_read(32'd160, acc_word);
        apb_read(32'd164, acc_word);
        report_test("misaligned and illegal");

        start_test();
        apb_write(32'(MEM_BYTES), acc_word, lcg_next());        // would alias word 0
        apb_write(32'(MEM_BYTES + 1), acc_byte, lcg_next());
        apb_write(32'(MEM_BYTES + 2), acc_half, lcg_next());
        apb_write(32'h0000_0800, acc_word, lcg_next());
        apb_write(32'hffff_fffc, acc_word, lcg_next());
        apb_read(32'(MEM_BYTES), acc_word);
        apb_read(32'(MEM_BYTES + 3), acc_byte_u);
        apb_read(32'hffff_fffe, acc_half);
        apb_read(32'(MEM_BYTES - 4), acc_word);                 // last word
        apb_read(32'd0, acc_word);
        report_test("out of range");

        // small window around words 48..51 now and then pushed past the end
        start_test();
        for (int n = 0; n < 200; n++) begin
            r = lcg_next();
            a = 32'd192 + 32'(r[27:24]);
            if (r[23:20] == 4'h0) begin
                a = 32'(MEM_BYTES) + 32'(r[27:24]);
            end
            if (r[31]) begin
                apb_write(a, access_e'(r[30:28]), lcg_next());
            end else begin
                apb_read(a, access_e'(r[30:28]));
            end
        end
        report_test("random");

        if (exp_err_q.size() != 0) begin
            n_errors++;
            $display("%0d transfers never completed", exp_err_q.size());
        end
        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+verilog
verilog/dmem_pkg.sv
verilog/dmem_if.sv
verilog/data_mem.sv
verilog/lsu_apb_slave.sv
verilog/dmem_subsys.sv
testbench/dmem_tb.sv

// File: Makefile
# verilator build and run for the data memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= dmem_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

PASS_MSG := *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
